//--- icache.f
+incdir+rtl
rtl/mem_bus_pkg.sv
rtl/icache_pkg.sv
rtl/icache_ifs.sv
rtl/icache_ram.sv
rtl/icache_lookup.sv
rtl/icache_refill.sv
rtl/icache_fetch_out.sv
rtl/icache_top.sv
tests/tb_mem_model.sv
tests/tb_icache.sv

//--- rtl/icache_fetch_out.sv
`timescale 1ns/1ps

module icache_fetch_out (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   flush_i,
    fetch_out_if.result            fo,
    output logic                   out_valid_o,
    output mem_bus_pkg::bus_addr_t out_addr_o,
    output icache_pkg::inst_pair_t out_insts_o,
    input  logic                   out_ready_i
);
    import icache_pkg::*;

    logic         out_valid_q;
    fetch_entry_t out_q;
    logic         load;

    // free when empty or draining this cycle
    assign fo.ready = !out_valid_q || out_ready_i;
    assign load     = fo.valid && fo.ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid_q <= 1'b0;
        end else if (flush_i) begin
            out_valid_q <= 1'b0;
        end else if (load) begin
            out_valid_q <= 1'b1;
        end else if (out_ready_i) begin
            out_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_q <= fo.entry;
        end
    end

    assign out_valid_o = out_valid_q;
    assign out_addr_o  = out_q.addr;
    assign out_insts_o = out_q.insts;

    a_out_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid_o && !out_ready_i && !flush_i
        |=> out_valid_o && $stable(out_addr_o) && $stable(out_insts_o)
    );

endmodule

//--- rtl/icache_ifs.sv
`timescale 1ns/1ps
`include "icache_params.svh"

// miss request and array write port between lookup and refill
interface refill_if;
    import icache_pkg::*;
    import mem_bus_pkg::*;

    logic                              miss_valid;
    bus_addr_t                         miss_addr;
    logic                              data_we;
    logic [$clog2(`ICACHE_WAYS)-1:0]   data_way;
    data_idx_t                         data_idx;
    inst_pair_t                        data_wdata;
    logic                              tag_we;
    tag_entry_t                        tag_wdata;
    logic                              done;

    modport lookup (
        output miss_valid, miss_addr,
        input  data_we, data_way, data_idx, data_wdata, tag_we, tag_wdata, done
    );

    modport refill (
        input  miss_valid, miss_addr,
        output data_we, data_way, data_idx, data_wdata, tag_we, tag_wdata, done
    );
endinterface

// hit result handed to the output register
interface fetch_out_if;
    import icache_pkg::*;

    logic         valid;
    fetch_entry_t entry;
    logic         ready;

    modport lookup (
        output valid, entry,
        input  ready
    );

    modport result (
        input  valid, entry,
        output ready
    );
endinterface

//--- rtl/icache_lookup.sv
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_lookup (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush_i,
    input  logic                  fetch_valid_i,
    input  mem_bus_pkg::bus_addr_t fetch_addr_i,
    output logic                  fetch_ready_o,
    refill_if.lookup              rf,
    fetch_out_if.lookup           fo
);
    import icache_pkg::*;

    logic                                     ready_en_q;
    logic                                     req_valid_q;
    logic [`ICACHE_ADDR_W-1:0]                req_addr_q;
    logic                                     miss_q;
    logic                                     accept;
    logic                                     rd_en;
    set_idx_t                                 rd_set;
    data_idx_t                                rd_didx;
    logic [`ICACHE_WAYS-1:0][`ICACHE_SETS-1:0] set_valid_q;
    logic [`ICACHE_WAYS-1:0]                  tag_ok_q;
    logic [`ICACHE_WAYS-1:0]                  way_hit;
    tag_entry_t                               tag_rd [`ICACHE_WAYS];
    inst_pair_t                               data_rd [`ICACHE_WAYS];
    inst_pair_t                               hit_pair;

    assign fetch_ready_o = ready_en_q && !flush_i && !miss_q
                           && (!req_valid_q || (|way_hit && fo.ready));
    assign accept = fetch_valid_i && fetch_ready_o;

    // a finished refill replays the read for the held address
    assign rd_en   = accept || rf.done;
    assign rd_set  = accept ? set_of(fetch_addr_i) : set_of(req_addr_q);
    assign rd_didx = accept ? data_idx_of(fetch_addr_i) : data_idx_of(req_addr_q);

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        icache_ram #(
            .entry_t (tag_entry_t),
            .DEPTH   (`ICACHE_SETS)
        ) u_tag_ram (
            .clk       (clk),
            .rd_en_i   (rd_en),
            .rd_idx_i  (rd_set),
            .rd_data_o (tag_rd[w]),
            .wr_en_i   (rf.tag_we && (rf.data_way == w)),
            .wr_idx_i  (set_of(req_addr_q)),
            .wr_data_i (rf.tag_wdata)
        );

        icache_ram #(
            .entry_t (inst_pair_t),
            .DEPTH   (DATA_DEPTH)
        ) u_data_ram (
            .clk       (clk),
            .rd_en_i   (rd_en),
            .rd_idx_i  (rd_didx),
            .rd_data_o (data_rd[w]),
            .wr_en_i   (rf.data_we && (rf.data_way == w)),
            .wr_idx_i  (rf.data_idx),
            .wr_data_i (rf.data_wdata)
        );

        assign way_hit[w] = tag_ok_q[w] && tag_rd[w].valid
                            && (tag_rd[w].tag == tag_of(req_addr_q));
    end

    always_comb begin
        hit_pair = data_rd[0];
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (way_hit[w]) begin
                hit_pair = data_rd[w];
            end
        end
    end

    assign fo.valid       = req_valid_q && |way_hit;
    assign fo.entry.addr  = req_addr_q;
    assign fo.entry.insts = hit_pair;

    assign rf.miss_valid = miss_q;
    assign rf.miss_addr  = req_addr_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ready_en_q  <= 1'b0;
            req_valid_q <= 1'b0;
            miss_q      <= 1'b0;
        end else begin
            ready_en_q <= 1'b1;
            if (flush_i) begin
                req_valid_q <= 1'b0;
            end else if (accept) begin
                req_valid_q <= 1'b1;
            end else if (fo.valid && fo.ready) begin
                req_valid_q <= 1'b0;
            end
            // stays up through a flush so the refill can finish
            if (rf.done) begin
                miss_q <= 1'b0;
            end else if (req_valid_q && !(|way_hit) && !flush_i) begin
                miss_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr_q <= fetch_addr_i;
        end
    end

    // sets never written since reset read as invalid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            set_valid_q <= '0;
            tag_ok_q    <= '0;
        end else begin
            if (rf.tag_we) begin
                set_valid_q[rf.data_way][set_of(req_addr_q)] <= 1'b1;
            end
            if (rd_en) begin
                for (int w = 0; w < `ICACHE_WAYS; w++) begin
                    tag_ok_q[w] <= set_valid_q[w][rd_set];
                end
            end
        end
    end

    // array writes only land while the lookup is stalled on a miss
    a_write_while_stalled: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rf.tag_we || rf.data_we) |-> rf.miss_valid && !rd_en
    );

endmodule

//--- rtl/icache_params.svh
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// cache geometry
`define ICACHE_WAYS 2
`define ICACHE_SETS 128
`define ICACHE_BLOCK_WORDS 8

// bus widths
`define ICACHE_ADDR_W 32
`define ICACHE_WORD_W 32

`endif

//--- rtl/icache_pkg.sv
`include "icache_params.svh"

package icache_pkg;

    // address split as | tag | set | pair | byte |
    localparam int unsigned SET_W      = $clog2(`ICACHE_SETS);
    localparam int unsigned SET_LSB    = $clog2(`ICACHE_BLOCK_WORDS * `ICACHE_WORD_W / 8);
    localparam int unsigned PAIR_LSB   = $clog2(2 * `ICACHE_WORD_W / 8);
    localparam int unsigned TAG_LSB    = SET_LSB + SET_W;
    localparam int unsigned TAG_W      = `ICACHE_ADDR_W - TAG_LSB;
    localparam int unsigned DATA_DEPTH = `ICACHE_SETS * `ICACHE_BLOCK_WORDS / 2;
    localparam int unsigned DATA_IDX_W = $clog2(DATA_DEPTH);
    localparam int unsigned PAIR_IDX_W = DATA_IDX_W - SET_W;

    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [SET_W-1:0]      set_idx_t;
    typedef logic [DATA_IDX_W-1:0] data_idx_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    // word [0] sits at the lower address
    typedef logic [1:0][`ICACHE_WORD_W-1:0] inst_pair_t;

    typedef struct packed {
        logic [`ICACHE_ADDR_W-1:0] addr;
        inst_pair_t                insts;
    } fetch_entry_t;

    function automatic tag_t tag_of(input logic [`ICACHE_ADDR_W-1:0] addr);
        return addr[`ICACHE_ADDR_W-1:TAG_LSB];
    endfunction

    function automatic set_idx_t set_of(input logic [`ICACHE_ADDR_W-1:0] addr);
        return addr[TAG_LSB-1:SET_LSB];
    endfunction

    function automatic data_idx_t data_idx_of(input logic [`ICACHE_ADDR_W-1:0] addr);
        return addr[TAG_LSB-1:PAIR_LSB];
    endfunction

endpackage

//--- rtl/icache_ram.sv
`timescale 1ns/1ps

module icache_ram #(
    parameter type         entry_t = logic [31:0],
    parameter int unsigned DEPTH   = 128
) (
    input  logic                     clk,
    input  logic                     rd_en_i,
    input  logic [$clog2(DEPTH)-1:0] rd_idx_i,
    output entry_t                   rd_data_o,
    input  logic                     wr_en_i,
    input  logic [$clog2(DEPTH)-1:0] wr_idx_i,
    input  entry_t                   wr_data_i
);

    entry_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_idx_i] <= wr_data_i;
        end
    end

    // output holds its last value while no read is issued
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_idx_i];
        end
    end

endmodule

//--- rtl/icache_refill.sv
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_refill (
    input  logic                   clk,
    input  logic                   rst_n,
    refill_if.refill               rf,
    output logic                   mem_req_valid_o,
    output mem_bus_pkg::bus_addr_t mem_req_addr_o,
    input  logic                   mem_req_ready_i,
    input  logic                   mem_resp_valid_i,
    input  mem_bus_pkg::bus_word_t mem_resp_data_i
);
    import icache_pkg::*;
    import mem_bus_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQUEST,
        S_COLLECT,
        S_FINISH
    } state_t;

    state_t                   state_q;
    logic [BEAT_W-1:0]        beat_cnt_q;
    bus_addr_t                blk_addr_q;
    bus_word_t                lo_q;
    logic                     way_q;
    logic [`ICACHE_SETS-1:0]  victim_q;
    logic                     beat_take;
    logic                     last_beat;

    assign beat_take = (state_q == S_COLLECT) && mem_resp_valid_i;
    assign last_beat = beat_cnt_q == BEAT_W'(BURST_LEN - 1);

    assign mem_req_valid_o = state_q == S_REQUEST;
    assign mem_req_addr_o  = blk_addr_q;

    // every odd beat completes a pair
    assign rf.data_we    = beat_take && beat_cnt_q[0];
    assign rf.data_way   = way_q;
    assign rf.data_idx   = {set_of(blk_addr_q), beat_cnt_q[BEAT_W-1:1]};
    assign rf.data_wdata = {mem_resp_data_i, lo_q};

    // tag goes in with the last pair, so the replay sees both
    assign rf.tag_we          = beat_take && last_beat;
    assign rf.tag_wdata.valid = 1'b1;
    assign rf.tag_wdata.tag   = tag_of(blk_addr_q);
    assign rf.done            = state_q == S_FINISH;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= S_IDLE;
            beat_cnt_q <= '0;
            victim_q   <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (rf.miss_valid) begin
                        state_q <= S_REQUEST;
                    end
                end
                S_REQUEST: begin
                    if (mem_req_ready_i) begin
                        state_q    <= S_COLLECT;
                        beat_cnt_q <= '0;
                    end
                end
                S_COLLECT: begin
                    if (beat_take) begin
                        beat_cnt_q <= beat_cnt_q + 1'b1;
                        if (last_beat) begin
                            state_q <= S_FINISH;
                        end
                    end
                end
                S_FINISH: begin
                    victim_q[set_of(blk_addr_q)] <= ~victim_q[set_of(blk_addr_q)];
                    state_q <= S_IDLE;
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == S_IDLE) && rf.miss_valid) begin
            blk_addr_q <= {rf.miss_addr[`ICACHE_ADDR_W-1:SET_LSB], {SET_LSB{1'b0}}};
            way_q      <= victim_q[set_of(rf.miss_addr)];
        end
        if (beat_take && !beat_cnt_q[0]) begin
            lo_q <= mem_resp_data_i;
        end
    end

    a_req_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_addr_o)
    );

endmodule

//--- rtl/icache_top.sv
`timescale 1ns/1ps

module icache_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   flush_i,
    // fetch side
    input  logic                   fetch_valid_i,
    input  mem_bus_pkg::bus_addr_t fetch_addr_i,
    output logic                   fetch_ready_o,
    // decoder side
    output logic                   out_valid_o,
    output mem_bus_pkg::bus_addr_t out_addr_o,
    output icache_pkg::inst_pair_t out_insts_o,
    input  logic                   out_ready_i,
    // memory side
    output logic                   mem_req_valid_o,
    output mem_bus_pkg::bus_addr_t mem_req_addr_o,
    input  logic                   mem_req_ready_i,
    input  logic                   mem_resp_valid_i,
    input  mem_bus_pkg::bus_word_t mem_resp_data_i
);

    refill_if    rf_if ();
    fetch_out_if fo_if ();

    icache_lookup u_lookup (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i       (flush_i),
        .fetch_valid_i (fetch_valid_i),
        .fetch_addr_i  (fetch_addr_i),
        .fetch_ready_o (fetch_ready_o),
        .rf            (rf_if.lookup),
        .fo            (fo_if.lookup)
    );

    icache_refill u_refill (
        .clk              (clk),
        .rst_n            (rst_n),
        .rf               (rf_if.refill),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_addr_o   (mem_req_addr_o),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_resp_valid_i (mem_resp_valid_i),
        .mem_resp_data_i  (mem_resp_data_i)
    );

    icache_fetch_out u_fetch_out (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush_i     (flush_i),
        .fo          (fo_if.result),
        .out_valid_o (out_valid_o),
        .out_addr_o  (out_addr_o),
        .out_insts_o (out_insts_o),
        .out_ready_i (out_ready_i)
    );

endmodule

//--- rtl/mem_bus_pkg.sv
`include "icache_params.svh"

package mem_bus_pkg;

    // beats per block burst
    localparam int unsigned BURST_LEN = `ICACHE_BLOCK_WORDS;
    localparam int unsigned BEAT_W    = $clog2(BURST_LEN);

    typedef logic [`ICACHE_ADDR_W-1:0] bus_addr_t;
    typedef logic [`ICACHE_WORD_W-1:0] bus_word_t;

endpackage

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_icache \
    -f icache.f -Mdir obj_dir -o sim_icache

output=$(./obj_dir/sim_icache)
echo "$output"

if grep -q "TESTS PASSED" <<< "$output"; then
    exit 0
fi
exit 1

//--- tests/tb_icache.sv
`timescale 1ns/1ps

module tb_icache;

    localparam int WAIT_LIMIT = 2000;

    logic        clk;
    logic        rst_n;
    logic        flush;
    logic        fetch_valid;
    logic [31:0] fetch_addr;
    logic        fetch_ready;
    logic        out_valid;
    logic [31:0] out_addr;
    logic [63:0] out_insts;
    logic        out_ready;
    logic        req_valid;
    logic [31:0] req_addr;
    logic        req_ready;
    logic        resp_valid;
    logic [31:0] resp_data;

    // scoreboard FIFO of accepted fetch addresses
    logic [31:0] exp_mem [256];
    logic [7:0]  head;
    logic [7:0]  tail;
    logic [7:0]  exp_count;
    logic [31:0] exp_addr;
    logic [63:0] exp_insts;
    int          req_cnt;

    logic        directed;
    logic        exp_miss;
    logic [31:0] cur_addr;
    int          base_req_cnt;
    logic [1:0]  ready_mode;
    integer      seed;
    logic [31:0] rand_addrs [48];
    int          data_errs;
    int          req_errs;
    int          hold_errs;
    int          reset_errs;
    int          timeouts;

    function automatic logic [31:0] expected_word(input logic [31:0] a);
        return a ^ 32'hA5A5_0000;
    endfunction

    icache_top dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .flush_i          (flush),
        .fetch_valid_i    (fetch_valid),
        .fetch_addr_i     (fetch_addr),
        .fetch_ready_o    (fetch_ready),
        .out_valid_o      (out_valid),
        .out_addr_o       (out_addr),
        .out_insts_o      (out_insts),
        .out_ready_i      (out_ready),
        .mem_req_valid_o  (req_valid),
        .mem_req_addr_o   (req_addr),
        .mem_req_ready_i  (req_ready),
        .mem_resp_valid_i (resp_valid),
        .mem_resp_data_i  (resp_data)
    );

    tb_mem_model u_mem (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid_i  (req_valid),
        .req_addr_i   (req_addr),
        .req_ready_o  (req_ready),
        .resp_valid_o (resp_valid),
        .resp_data_o  (resp_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    assign exp_count = tail - head;
    assign exp_addr  = exp_mem[head];
    assign exp_insts = {expected_word(exp_addr + 32'd4), expected_word(exp_addr)};

    always @(posedge clk) begin
        if (!rst_n) begin
            head    <= '0;
            tail    <= '0;
            req_cnt <= 0;
        end else begin
            if (fetch_valid && fetch_ready) begin
                exp_mem[tail] <= fetch_addr;
                tail          <= tail + 8'd1;
            end
            // no fetch is accepted in a flush cycle
            if (flush) begin
                head <= tail;
            end else if (out_valid && out_ready) begin
                head <= head + 8'd1;
            end
            if (req_valid && req_ready) begin
                req_cnt <= req_cnt + 1;
            end
        end
    end

    // ready_mode selects decoder ready as 0 high, 1 low or 2 random
    initial begin
        logic [1:0] mode;
        out_ready = 1'b1;
        forever begin
            @(posedge clk);
            mode = ready_mode;
            #2;
            if (mode == 2'd2) begin
                out_ready = ($random(seed) & 3) != 0;
            end else begin
                out_ready = (mode == 2'd0);
            end
        end
    end

    a_data: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid && out_ready
        |-> exp_count != 0 && out_addr == exp_addr && out_insts == exp_insts
    ) else begin
        data_errs++;
        $display("ERROR @%0t: output %h %h, expected %h %h (queued %0d)",
                 $time, out_addr, out_insts, exp_addr, exp_insts, exp_count);
    end

    a_req_addr: assert property (
        @(posedge clk) disable iff (!rst_n)
        req_valid && req_ready
        |-> req_addr[4:0] == 5'd0
            && (!directed || (exp_miss && req_addr == {cur_addr[31:5], 5'd0}))
    ) else begin
        req_errs++;
        $display("ERROR @%0t: unexpected memory request to %h", $time, req_addr);
    end

    a_req_count: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid && out_ready && directed |-> req_cnt == base_req_cnt + exp_miss
    ) else begin
        req_errs++;
        $display("ERROR @%0t: %0d memory requests for fetch %h, expected %0d",
                 $time, req_cnt - base_req_cnt, cur_addr, exp_miss);
    end

    a_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready && !flush
        |=> out_valid && $stable(out_addr) && $stable(out_insts)
    ) else begin
        hold_errs++;
        $display("ERROR @%0t: output changed while stalled", $time);
    end

    a_reset_idle: assert property (
        @(posedge clk) !rst_n |=> !out_valid && !req_valid
    ) else begin
        reset_errs++;
        $display("ERROR @%0t: output or memory request valid after reset", $time);
    end

    a_ready_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> !fetch_ready
    ) else begin
        reset_errs++;
        $display("ERROR @%0t: fetch ready in the first cycle after reset", $time);
    end

    task automatic send_fetch(input logic [31:0] addr);
        int waited;
        waited      = 0;
        fetch_valid = 1'b1;
        fetch_addr  = addr;
        #1;
        while (!fetch_ready && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #3;
            waited++;
        end
        if (!fetch_ready) begin
            timeouts++;
            $display("timeout: fetch to %h was never accepted", addr);
        end
        @(posedge clk);
        #2;
        fetch_valid = 1'b0;
    endtask

    task automatic wait_drain(input string what);
        int waited;
        waited = 0;
        while (exp_count != 0 && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (exp_count != 0) begin
            timeouts++;
            $display("timeout: %0d outputs missing after %s", exp_count, what);
        end
    endtask

    task automatic wait_out_valid();
        int waited;
        waited = 0;
        while (!out_valid && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (!out_valid) begin
            timeouts++;
            $display("timeout: no output became valid");
        end
    endtask

    task automatic fetch_and_check(input logic [31:0] addr, input logic miss);
        directed     = 1'b1;
        exp_miss     = miss;
        cur_addr     = addr;
        base_req_cnt = req_cnt;
        send_fetch(addr);
        wait_drain("directed fetch");
    endtask

    initial begin
        rst_n        = 1'b0;
        flush        = 1'b0;
        fetch_valid  = 1'b0;
        fetch_addr   = '0;
        directed     = 1'b0;
        exp_miss     = 1'b0;
        cur_addr     = '0;
        base_req_cnt = 0;
        ready_mode   = 2'd0;
        seed         = 32'h8079;
        data_errs    = 0;
        req_errs     = 0;
        hold_errs    = 0;
        reset_errs   = 0;
        timeouts     = 0;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // cold miss, then hits in the same block
        fetch_and_check(32'h0000_0100, 1'b1);
        fetch_and_check(32'h0000_0108, 1'b0);
        fetch_and_check(32'h0000_0118, 1'b0);

        // A, B, C all on set 2
        fetch_and_check(32'h0000_1040, 1'b1);
        fetch_and_check(32'h0000_2040, 1'b1);
        fetch_and_check(32'h0000_3040, 1'b1);
        fetch_and_check(32'h0000_2040, 1'b0);
        fetch_and_check(32'h0000_1040, 1'b1);

        // decoder stalled for a while
        ready_mode   = 2'd1;
        exp_miss     = 1'b0;
        base_req_cnt = req_cnt;
        send_fetch(32'h0000_0100);
        send_fetch(32'h0000_0108);
        wait_out_valid();
        repeat (10) @(posedge clk);
        #2;
        ready_mode = 2'd0;
        wait_drain("stalled outputs");

        directed = 1'b0;
        for (int i = 0; i < 48; i++) begin
            rand_addrs[i] = $random(seed) & 32'h0000_3FF8;
        end
        ready_mode = 2'd2;
        for (int i = 0; i < 48; i++) begin
            send_fetch(rand_addrs[i]);
        end
        ready_mode = 2'd0;
        wait_drain("random fetches");

        // flush with one output held and one refill running
        ready_mode = 2'd1;
        send_fetch(32'h0000_0108);
        send_fetch(32'h0000_6000);
        wait_out_valid();
        repeat (3) @(posedge clk);
        #2;
        flush = 1'b1;
        @(posedge clk);
        #2;
        flush      = 1'b0;
        ready_mode = 2'd0;
        send_fetch(32'h0000_6000);
        wait_drain("fetch after flush");
        repeat (4) @(posedge clk);
        #2;

        $display("errors: data %0d, request %0d, hold %0d, reset %0d, timeout %0d",
                 data_errs, req_errs, hold_errs, reset_errs, timeouts);
        if (data_errs + req_errs + hold_errs + reset_errs + timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- tests/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req_valid_i,
    input  logic [31:0] req_addr_i,
    output logic        req_ready_o,
    output logic        resp_valid_o,
    output logic [31:0] resp_data_o
);

    integer seed;

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return a ^ 32'hA5A5_0000;
    endfunction

    initial begin
        logic [31:0] base;
        int          delay;
        int          beat;
        seed         = 32'h8079;
        req_ready_o  = 1'b0;
        resp_valid_o = 1'b0;
        resp_data_o  = '0;
        forever begin
            @(posedge clk);
            #1;
            if (rst_n && req_valid_i) begin
                base  = req_addr_i;
                delay = $random(seed) & 3;
                for (int i = 0; i < delay; i++) begin
                    @(posedge clk);
                    #1;
                end
                #1;
                req_ready_o = 1'b1;
                @(posedge clk);
                #2;
                req_ready_o = 1'b0;
                beat = 0;
                // beats in address order, with random idle cycles
                while (beat < 8) begin
                    if (($random(seed) & 3) == 0) begin
                        resp_valid_o = 1'b0;
                    end else begin
                        resp_valid_o = 1'b1;
                        resp_data_o  = mem_word(base + 32'(beat * 4));
                        beat++;
                    end
                    @(posedge clk);
                    #2;
                end
                resp_valid_o = 1'b0;
            end
        end
    end

endmodule
